//--- src/rv5_defines.svh
`ifndef RV5_DEFINES_SVH
`define RV5_DEFINES_SVH

// machine width and register count
`define RV5_XLEN 32
`define RV5_REG_COUNT 32

// program counter
`define RV5_RESET_PC 32'h0000_0000
`define RV5_PC_STEP 32'd4

// addi x0, x0, 0
`define RV5_NOP 32'h0000_0013

// major opcodes of the supported subset
`define RV5_OP_REG 7'b0110011
`define RV5_OP_IMM 7'b0010011
`define RV5_OP_LUI 7'b0110111
`define RV5_OP_LOAD 7'b0000011
`define RV5_OP_STORE 7'b0100011
`define RV5_OP_BRANCH 7'b1100011
`define RV5_OP_JAL 7'b1101111

`endif

//--- src/rv5_pkg.sv
`include "rv5_defines.svh"

package rv5_pkg;

    typedef logic [`RV5_XLEN-1:0] word_t;
    typedef logic [4:0] reg_addr_t;

    // alu function, zero encoding is add
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR = 3'd3,
        ALU_XOR = 3'd4,
        ALU_PASS2 = 3'd5
    } alu_op_e;

    typedef enum logic {
        OP1_PC = 1'b0,
        OP1_RS1 = 1'b1
    } op1_sel_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_LINK = 2'd1,
        WB_MEM = 2'd2
    } wb_sel_e;

    // decoded control, all zero is a bubble
    typedef struct packed {
        alu_op_e alu_op;
        op1_sel_e op1_sel;
        logic is_branch;
        logic is_bne;
        logic is_jump;
        logic mem_read;
        logic mem_write;
        wb_sel_e wb_sel;
        logic reg_write;
        reg_addr_t rd;
    } ctrl_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic read;
        logic write;
    } dmem_req_t;

    typedef struct packed {
        logic we;
        reg_addr_t addr;
        word_t data;
    } wb_t;

endpackage

//--- src/rv5_fetch.sv
`timescale 1ns/1ps
`include "rv5_defines.svh"

module rv5_fetch (
    input logic clk,
    input logic rst_n,
    input rv5_pkg::word_t instruction,
    input logic stall,
    input logic kill,
    input rv5_pkg::word_t target,
    output rv5_pkg::word_t pc,
    output rv5_pkg::word_t dec_pc,
    output rv5_pkg::word_t dec_instr
);
    import rv5_pkg::*;

    word_t pc_next;

    // redirect wins over a hazard hold
    always_comb begin
        if (kill) begin
            pc_next = target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + `RV5_PC_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RV5_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // fetch/decode register, bubble on hold or redirect
    always_ff @(posedge clk) begin
        dec_pc <= pc;
        if (!rst_n) begin
            dec_instr <= `RV5_NOP;
        end else if (kill || stall) begin
            dec_instr <= `RV5_NOP;
        end else begin
            dec_instr <= instruction;
        end
    end

endmodule

//--- src/rv5_decode.sv
`timescale 1ns/1ps
`include "rv5_defines.svh"

module rv5_decode (
    input logic clk,
    input logic rst_n,
    input logic kill,
    input rv5_pkg::word_t dec_pc,
    input rv5_pkg::word_t dec_instr,
    input rv5_pkg::word_t rs1_data,
    input rv5_pkg::word_t rs2_data,
    output rv5_pkg::reg_addr_t rs1_addr,
    output rv5_pkg::reg_addr_t rs2_addr,
    output rv5_pkg::reg_addr_t dec_rd,
    output logic dec_reg_write,
    output rv5_pkg::ctrl_t exe_ctrl,
    output rv5_pkg::word_t exe_pc,
    output rv5_pkg::word_t exe_op1,
    output rv5_pkg::word_t exe_op2,
    output rv5_pkg::word_t exe_rs2
);
    import rv5_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;
    ctrl_t dec_ctrl;
    word_t op1;
    word_t op2;

    // funct3 to alu op, sub only for register-register
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000: return sub ? ALU_SUB : ALU_ADD;
            3'b100: return ALU_XOR;
            3'b110: return ALU_OR;
            3'b111: return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign opcode = dec_instr[6:0];
    assign funct3 = dec_instr[14:12];
    assign rs1_addr = dec_instr[19:15];
    assign rs2_addr = dec_instr[24:20];

    // immediate formats
    assign imm_i = {{20{dec_instr[31]}}, dec_instr[31:20]};
    assign imm_s = {{20{dec_instr[31]}}, dec_instr[31:25], dec_instr[11:7]};
    assign imm_b = {{19{dec_instr[31]}}, dec_instr[31], dec_instr[7],
                    dec_instr[30:25], dec_instr[11:8], 1'b0};
    assign imm_u = {dec_instr[31:12], 12'b0};
    assign imm_j = {{11{dec_instr[31]}}, dec_instr[31], dec_instr[19:12],
                    dec_instr[20], dec_instr[30:21], 1'b0};

    always_comb begin
        dec_ctrl = '0;
        dec_ctrl.op1_sel = OP1_RS1;
        dec_ctrl.rd = dec_instr[11:7];
        op2 = rs2_data;
        case (opcode)
            `RV5_OP_REG: begin
                dec_ctrl.alu_op = alu_from_funct(funct3, dec_instr[30]);
                dec_ctrl.reg_write = 1'b1;
            end
            `RV5_OP_IMM: begin
                dec_ctrl.alu_op = alu_from_funct(funct3, 1'b0);
                dec_ctrl.reg_write = 1'b1;
                op2 = imm_i;
            end
            `RV5_OP_LUI: begin
                dec_ctrl.alu_op = ALU_PASS2;
                dec_ctrl.reg_write = 1'b1;
                op2 = imm_u;
            end
            `RV5_OP_LOAD: begin
                dec_ctrl.mem_read = 1'b1;
                dec_ctrl.wb_sel = WB_MEM;
                dec_ctrl.reg_write = 1'b1;
                op2 = imm_i;
            end
            `RV5_OP_STORE: begin
                dec_ctrl.mem_write = 1'b1;
                op2 = imm_s;
            end
            `RV5_OP_BRANCH: begin
                // beq/bne differ in funct3 bit 0
                dec_ctrl.is_branch = 1'b1;
                dec_ctrl.is_bne = funct3[0];
                op2 = imm_b;
            end
            `RV5_OP_JAL: begin
                dec_ctrl.op1_sel = OP1_PC;
                dec_ctrl.is_jump = 1'b1;
                dec_ctrl.wb_sel = WB_LINK;
                dec_ctrl.reg_write = 1'b1;
                op2 = imm_j;
            end
            default: begin
                // unsupported opcode behaves as a bubble
                dec_ctrl.reg_write = 1'b0;
            end
        endcase
    end

    assign op1 = (dec_ctrl.op1_sel == OP1_PC) ? dec_pc : rs1_data;

    assign dec_rd = dec_ctrl.rd;
    assign dec_reg_write = dec_ctrl.reg_write;

    // decode/execute register
    always_ff @(posedge clk) begin
        exe_pc <= dec_pc;
        exe_op1 <= op1;
        exe_op2 <= op2;
        exe_rs2 <= rs2_data;
        if (!rst_n) begin
            exe_ctrl <= '0;
        end else if (kill) begin
            exe_ctrl <= '0;
        end else begin
            exe_ctrl <= dec_ctrl;
        end
    end

endmodule

//--- src/rv5_regfile.sv
`timescale 1ns/1ps
`include "rv5_defines.svh"

module rv5_regfile (
    input logic clk,
    input logic rst_n,
    input rv5_pkg::reg_addr_t rs1_addr,
    input rv5_pkg::reg_addr_t rs2_addr,
    output rv5_pkg::word_t rs1_data,
    output rv5_pkg::word_t rs2_data,
    input rv5_pkg::wb_t wb,
    input rv5_pkg::reg_addr_t dbg_reg,
    output rv5_pkg::word_t dbg_data
);
    import rv5_pkg::*;

    word_t regs [`RV5_REG_COUNT];

    // x0 is cleared by reset and never written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV5_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // three asynchronous read ports
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];
    assign dbg_data = regs[dbg_reg];

endmodule

//--- src/rv5_execute.sv
`timescale 1ns/1ps
`include "rv5_defines.svh"

module rv5_execute (
    input logic clk,
    input logic rst_n,
    input rv5_pkg::ctrl_t exe_ctrl,
    input rv5_pkg::word_t exe_pc,
    input rv5_pkg::word_t exe_op1,
    input rv5_pkg::word_t exe_op2,
    input rv5_pkg::word_t exe_rs2,
    output logic kill,
    output rv5_pkg::word_t target,
    output rv5_pkg::reg_addr_t exe_rd,
    output logic exe_reg_write,
    output rv5_pkg::ctrl_t mem_ctrl,
    output rv5_pkg::word_t mem_result,
    output rv5_pkg::word_t mem_store
);
    import rv5_pkg::*;

    word_t alu_out;
    word_t result;
    logic is_eq;

    always_comb begin
        case (exe_ctrl.alu_op)
            ALU_ADD: alu_out = exe_op1 + exe_op2;
            ALU_SUB: alu_out = exe_op1 - exe_op2;
            ALU_AND: alu_out = exe_op1 & exe_op2;
            ALU_OR: alu_out = exe_op1 | exe_op2;
            ALU_XOR: alu_out = exe_op1 ^ exe_op2;
            ALU_PASS2: alu_out = exe_op2;
            default: alu_out = exe_op1 + exe_op2;
        endcase
    end

    // branch condition, op1 carries rs1 for branches
    assign is_eq = (exe_op1 == exe_rs2);

    // op2 holds the b or j immediate here
    assign target = exe_pc + exe_op2;
    assign kill = exe_ctrl.is_jump || (exe_ctrl.is_branch && (is_eq ^ exe_ctrl.is_bne));

    assign exe_rd = exe_ctrl.rd;
    assign exe_reg_write = exe_ctrl.reg_write;

    // jal writes the return address
    assign result = (exe_ctrl.wb_sel == WB_LINK) ? exe_pc + `RV5_PC_STEP : alu_out;

    // execute/memory register
    always_ff @(posedge clk) begin
        mem_result <= result;
        mem_store <= exe_rs2;
        if (!rst_n) begin
            mem_ctrl <= '0;
        end else begin
            mem_ctrl <= exe_ctrl;
        end
    end

endmodule

//--- src/rv5_memwb.sv
`timescale 1ns/1ps

module rv5_memwb (
    input logic clk,
    input logic rst_n,
    input rv5_pkg::ctrl_t mem_ctrl,
    input rv5_pkg::word_t mem_result,
    input rv5_pkg::word_t mem_store,
    input rv5_pkg::word_t dmem_rdata,
    output rv5_pkg::dmem_req_t dmem_req,
    output rv5_pkg::reg_addr_t mem_rd,
    output logic mem_reg_write,
    output rv5_pkg::wb_t wb
);
    import rv5_pkg::*;

    word_t wb_data;

    // ram request straight from the memory stage
    always_comb begin
        dmem_req.addr = mem_result;
        dmem_req.wdata = mem_store;
        dmem_req.read = mem_ctrl.mem_read;
        dmem_req.write = mem_ctrl.mem_write;
    end

    assign mem_rd = mem_ctrl.rd;
    assign mem_reg_write = mem_ctrl.reg_write;

    // load data returns in the same cycle
    assign wb_data = (mem_ctrl.wb_sel == WB_MEM) ? dmem_rdata : mem_result;

    // memory/writeback register
    always_ff @(posedge clk) begin
        wb.addr <= mem_ctrl.rd;
        wb.data <= wb_data;
        if (!rst_n) begin
            wb.we <= 1'b0;
        end else begin
            wb.we <= mem_ctrl.reg_write;
        end
    end

endmodule

//--- src/rv5_hazard.sv
`timescale 1ns/1ps

module rv5_hazard (
    input rv5_pkg::word_t instruction,
    input rv5_pkg::reg_addr_t dec_rd,
    input logic dec_reg_write,
    input rv5_pkg::reg_addr_t exe_rd,
    input logic exe_reg_write,
    input rv5_pkg::reg_addr_t mem_rd,
    input logic mem_reg_write,
    input rv5_pkg::wb_t wb,
    output logic stall
);
    import rv5_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    logic rs1_busy;
    logic rs2_busy;

    // raw source fields of the fetched word
    assign rs1 = instruction[19:15];
    assign rs2 = instruction[24:20];

    // pending writes in decode, execute, memory and writeback
    assign rs1_busy = (rs1 != '0) && ((dec_reg_write && rs1 == dec_rd) ||
                                      (exe_reg_write && rs1 == exe_rd) ||
                                      (mem_reg_write && rs1 == mem_rd) ||
                                      (wb.we && rs1 == wb.addr));
    assign rs2_busy = (rs2 != '0) && ((dec_reg_write && rs2 == dec_rd) ||
                                      (exe_reg_write && rs2 == exe_rd) ||
                                      (mem_reg_write && rs2 == mem_rd) ||
                                      (wb.we && rs2 == wb.addr));

    assign stall = rs1_busy || rs2_busy;

endmodule

//--- src/rv5_core.sv
`timescale 1ns/1ps

module rv5_core (
    input logic clk,
    input logic rst_n,
    output rv5_pkg::word_t pc,
    input rv5_pkg::word_t instruction,
    output rv5_pkg::dmem_req_t dmem_req,
    input rv5_pkg::word_t dmem_rdata,
    input rv5_pkg::reg_addr_t dbg_reg,
    output rv5_pkg::word_t dbg_data
);
    import rv5_pkg::*;

    // hazard and redirect
    logic stall;
    logic kill;
    word_t target;

    // fetch to decode
    word_t dec_pc;
    word_t dec_instr;

    // decode side
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t rs1_data;
    word_t rs2_data;
    reg_addr_t dec_rd;
    logic dec_reg_write;

    // decode to execute
    ctrl_t exe_ctrl;
    word_t exe_pc;
    word_t exe_op1;
    word_t exe_op2;
    word_t exe_rs2;
    reg_addr_t exe_rd;
    logic exe_reg_write;

    // execute to memory
    ctrl_t mem_ctrl;
    word_t mem_result;
    word_t mem_store;
    reg_addr_t mem_rd;
    logic mem_reg_write;

    // writeback
    wb_t wb;

    rv5_fetch u_fetch (
        .clk(clk),
        .rst_n(rst_n),
        .instruction(instruction),
        .stall(stall),
        .kill(kill),
        .target(target),
        .pc(pc),
        .dec_pc(dec_pc),
        .dec_instr(dec_instr)
    );

    rv5_decode u_decode (
        .clk(clk),
        .rst_n(rst_n),
        .kill(kill),
        .dec_pc(dec_pc),
        .dec_instr(dec_instr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .dec_rd(dec_rd),
        .dec_reg_write(dec_reg_write),
        .exe_ctrl(exe_ctrl),
        .exe_pc(exe_pc),
        .exe_op1(exe_op1),
        .exe_op2(exe_op2),
        .exe_rs2(exe_rs2)
    );

    rv5_regfile u_regfile (
        .clk(clk),
        .rst_n(rst_n),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wb(wb),
        .dbg_reg(dbg_reg),
        .dbg_data(dbg_data)
    );

    rv5_execute u_execute (
        .clk(clk),
        .rst_n(rst_n),
        .exe_ctrl(exe_ctrl),
        .exe_pc(exe_pc),
        .exe_op1(exe_op1),
        .exe_op2(exe_op2),
        .exe_rs2(exe_rs2),
        .kill(kill),
        .target(target),
        .exe_rd(exe_rd),
        .exe_reg_write(exe_reg_write),
        .mem_ctrl(mem_ctrl),
        .mem_result(mem_result),
        .mem_store(mem_store)
    );

    rv5_memwb u_memwb (
        .clk(clk),
        .rst_n(rst_n),
        .mem_ctrl(mem_ctrl),
        .mem_result(mem_result),
        .mem_store(mem_store),
        .dmem_rdata(dmem_rdata),
        .dmem_req(dmem_req),
        .mem_rd(mem_rd),
        .mem_reg_write(mem_reg_write),
        .wb(wb)
    );

    rv5_hazard u_hazard (
        .instruction(instruction),
        .dec_rd(dec_rd),
        .dec_reg_write(dec_reg_write),
        .exe_rd(exe_rd),
        .exe_reg_write(exe_reg_write),
        .mem_rd(mem_rd),
        .mem_reg_write(mem_reg_write),
        .wb(wb),
        .stall(stall)
    );

endmodule

//--- bench/rv5_clock_gen.sv
`timescale 1ns/1ps

module rv5_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period, first rising edge at 4 ns
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // low across the first 16 rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (16) @(negedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- bench/rv5_assert.sv
`timescale 1ns/1ps

module rv5_assert (
    input logic clk,
    input logic rst_n,
    input rv5_pkg::word_t pc,
    input rv5_pkg::dmem_req_t dmem_req,
    input logic stall,
    input logic kill
);

    // number of failed properties so far
    int failures = 0;

    // one ram port, one access kind per cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_req.read && dmem_req.write))
        else begin
            failures++;
            $error("data memory read and write enables are high together");
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00)
        else begin
            failures++;
            $error("pc is not word aligned");
        end

    // a hazard hold without a redirect keeps the fetch address
    assert property (@(posedge clk) disable iff (!rst_n)
        (stall && !kill) |=> (pc == $past(pc)))
        else begin
            failures++;
            $error("pc moved while fetch was stalled");
        end

endmodule

bind rv5_core rv5_assert u_assert (
    .clk(clk),
    .rst_n(rst_n),
    .pc(pc),
    .dmem_req(dmem_req),
    .stall(stall),
    .kill(kill)
);

//--- bench/rv5_tb.sv
`timescale 1ns/1ps
`include "rv5_defines.svh"

module rv5_tb;
    import rv5_pkg::*;

    localparam int PROG_LEN = 48;
    localparam int HALT_IDX = PROG_LEN - 1;
    localparam int MEM_WORDS = 64;
    localparam word_t HALT_PC = HALT_IDX * 4;
    localparam int RESET_TIMEOUT = 100;
    localparam int HALT_TIMEOUT = 4000;
    localparam int HALT_SETTLE = 10;

    typedef enum int {
        I_ADD, I_SUB, I_AND, I_OR, I_XOR,
        I_ADDI, I_ANDI, I_ORI, I_XORI, I_LUI,
        I_LW, I_SW, I_BEQ, I_BNE, I_JAL
    } kind_e;

    logic clk;
    logic rst_n;
    word_t pc;
    word_t instruction;
    dmem_req_t dmem_req;
    word_t dmem_rdata;
    reg_addr_t dbg_reg;
    word_t dbg_data;

    word_t rom [MEM_WORDS];
    word_t ram [MEM_WORDS];

    // generated program in decoded form, read by the model
    kind_e prog_kind [PROG_LEN];
    reg_addr_t prog_rd [PROG_LEN];
    reg_addr_t prog_rs1 [PROG_LEN];
    reg_addr_t prog_rs2 [PROG_LEN];
    word_t prog_imm [PROG_LEN];
    int prog_tgt [PROG_LEN];

    word_t model_regs [`RV5_REG_COUNT];
    word_t model_ram [MEM_WORDS];
    word_t store_addr_q [$];
    word_t store_data_q [$];
    int stores_seen = 0;
    logic [31:0] lfsr_state;

    rv5_clock_gen clock0 (
        .clk(clk),
        .rst_n(rst_n)
    );

    rv5_core dut0 (
        .clk(clk),
        .rst_n(rst_n),
        .pc(pc),
        .instruction(instruction),
        .dmem_req(dmem_req),
        .dmem_rdata(dmem_rdata),
        .dbg_reg(dbg_reg),
        .dbg_data(dbg_data)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "count mismatch");
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // initial ram contents, mixes every address bit
    function automatic word_t fill_word(input int idx);
        return (word_t'(idx) * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
    endfunction

    function automatic word_t encode(input int i);
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t imm;
        rd = prog_rd[i];
        rs1 = prog_rs1[i];
        rs2 = prog_rs2[i];
        imm = prog_imm[i];
        case (prog_kind[i])
            I_ADD: return {7'b0000000, rs2, rs1, 3'b000, rd, `RV5_OP_REG};
            I_SUB: return {7'b0100000, rs2, rs1, 3'b000, rd, `RV5_OP_REG};
            I_AND: return {7'b0000000, rs2, rs1, 3'b111, rd, `RV5_OP_REG};
            I_OR: return {7'b0000000, rs2, rs1, 3'b110, rd, `RV5_OP_REG};
            I_XOR: return {7'b0000000, rs2, rs1, 3'b100, rd, `RV5_OP_REG};
            I_ADDI: return {imm[11:0], rs1, 3'b000, rd, `RV5_OP_IMM};
            I_ANDI: return {imm[11:0], rs1, 3'b111, rd, `RV5_OP_IMM};
            I_ORI: return {imm[11:0], rs1, 3'b110, rd, `RV5_OP_IMM};
            I_XORI: return {imm[11:0], rs1, 3'b100, rd, `RV5_OP_IMM};
            I_LUI: return {imm[31:12], rd, `RV5_OP_LUI};
            I_LW: return {imm[11:0], rs1, 3'b010, rd, `RV5_OP_LOAD};
            I_SW: return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV5_OP_STORE};
            I_BEQ: return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11],
                           `RV5_OP_BRANCH};
            I_BNE: return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11],
                           `RV5_OP_BRANCH};
            default: return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV5_OP_JAL};
        endcase
    endfunction

    task automatic gen_program();
        logic [31:0] r;
        int span;
        for (int i = 0; i < HALT_IDX; i++) begin
            take_bits(4, r);
            prog_kind[i] = kind_e'(r % 15);
            // x0 to x7 only, so dependences are dense
            take_bits(3, r);
            prog_rd[i] = reg_addr_t'(r);
            take_bits(3, r);
            prog_rs1[i] = reg_addr_t'(r);
            take_bits(3, r);
            prog_rs2[i] = reg_addr_t'(r);
            take_bits(12, r);
            prog_imm[i] = {{20{r[11]}}, r[11:0]};
            prog_tgt[i] = i + 1;
            case (prog_kind[i])
                I_LUI: begin
                    take_bits(20, r);
                    prog_imm[i] = {r[19:0], 12'b0};
                end
                I_LW, I_SW: begin
                    take_bits(6, r);
                    prog_rs1[i] = '0;
                    prog_imm[i] = {24'b0, r[5:0], 2'b00};
                end
                I_BEQ, I_BNE, I_JAL: begin
                    // forward only, at most up to the halt word
                    span = HALT_IDX - i;
                    take_bits(6, r);
                    prog_tgt[i] = i + 1 + int'(r % span);
                    prog_imm[i] = word_t'((prog_tgt[i] - i) * 4);
                end
                default: ;
            endcase
            rom[i] = encode(i);
        end
        // jal x0, 0 at the halt address
        prog_kind[HALT_IDX] = I_JAL;
        prog_rd[HALT_IDX] = '0;
        prog_rs1[HALT_IDX] = '0;
        prog_rs2[HALT_IDX] = '0;
        prog_imm[HALT_IDX] = '0;
        prog_tgt[HALT_IDX] = HALT_IDX;
        rom[HALT_IDX] = encode(HALT_IDX);
        for (int w = PROG_LEN; w < MEM_WORDS; w++) begin
            rom[w] = `RV5_NOP;
        end
    endtask

    task automatic run_model();
        int idx;
        int next;
        word_t a;
        word_t b;
        word_t imm;
        word_t res;
        logic wr;
        for (int r = 0; r < `RV5_REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        for (int w = 0; w < MEM_WORDS; w++) begin
            model_ram[w] = fill_word(w);
        end
        idx = 0;
        for (int n = 0; n < PROG_LEN && idx != HALT_IDX; n++) begin
            a = model_regs[prog_rs1[idx]];
            b = model_regs[prog_rs2[idx]];
            imm = prog_imm[idx];
            next = idx + 1;
            wr = 1'b1;
            res = '0;
            case (prog_kind[idx])
                I_ADD: res = a + b;
                I_SUB: res = a - b;
                I_AND: res = a & b;
                I_OR: res = a | b;
                I_XOR: res = a ^ b;
                I_ADDI: res = a + imm;
                I_ANDI: res = a & imm;
                I_ORI: res = a | imm;
                I_XORI: res = a ^ imm;
                I_LUI: res = imm;
                I_LW: res = model_ram[(a + imm) >> 2];
                I_SW: begin
                    wr = 1'b0;
                    model_ram[(a + imm) >> 2] = b;
                    store_addr_q.push_back(a + imm);
                    store_data_q.push_back(b);
                end
                I_BEQ: begin
                    wr = 1'b0;
                    if (a == b) begin
                        next = prog_tgt[idx];
                    end
                end
                I_BNE: begin
                    wr = 1'b0;
                    if (a != b) begin
                        next = prog_tgt[idx];
                    end
                end
                default: begin
                    res = word_t'((idx + 1) * 4);
                    next = prog_tgt[idx];
                end
            endcase
            if (wr && prog_rd[idx] != '0) begin
                model_regs[prog_rd[idx]] = res;
            end
            idx = next;
        end
        if (idx != HALT_IDX) begin
            abort_run("reference model did not reach the halt instruction");
        end
    endtask

    // rom and ram answer in the same cycle
    always_comb begin
        if (pc < MEM_WORDS * 4) begin
            instruction = rom[pc[7:2]];
        end else begin
            instruction = `RV5_NOP;
        end
    end

    always_comb begin
        dmem_rdata = ram[dmem_req.addr[7:2]];
    end

    always @(posedge clk) begin
        if (dmem_req.write === 1'b1) begin
            ram[dmem_req.addr[7:2]] <= dmem_req.wdata;
        end
    end

    // each store must be the next one of the model, in order
    always @(negedge clk) begin
        if (dmem_req.write === 1'b1) begin
            if (stores_seen >= store_addr_q.size()) begin
                abort_run("the core issued more stores than the reference model");
            end else begin
                check_word("dmem_req.addr", dmem_req.addr, store_addr_q[stores_seen]);
                check_word("dmem_req.wdata", dmem_req.wdata, store_data_q[stores_seen]);
                stores_seen++;
            end
        end
    end

    // a failed property in the bound checker ends the run
    always @(negedge clk) begin
        if (dut0.u_assert.failures != 0) begin
            abort_run("an assertion on the core failed");
        end
    end

    task automatic check_reset();
        int cycles;
        logic released;
        cycles = 0;
        released = 1'b0;
        while (!released) begin
            @(negedge clk);
            check_word("pc", pc, `RV5_RESET_PC);
            check_flag("dmem_req.read", dmem_req.read, 1'b0);
            check_flag("dmem_req.write", dmem_req.write, 1'b0);
            @(posedge clk);
            released = (rst_n === 1'b1);
            cycles++;
            if (!released && cycles > RESET_TIMEOUT) begin
                abort_run("reset was never released");
            end
        end
    endtask

    // jal x0, 0 refetches itself, so pc cycles over the halt word and the two after it
    task automatic wait_halt();
        int cycles;
        int parked;
        cycles = 0;
        parked = 0;
        while (parked < HALT_SETTLE) begin
            @(negedge clk);
            cycles++;
            if (pc >= HALT_PC && pc <= HALT_PC + 8) begin
                parked++;
            end else begin
                parked = 0;
            end
            if (cycles > HALT_TIMEOUT) begin
                abort_run("timed out waiting for the core to reach the halt loop");
            end
        end
    endtask

    task automatic check_registers();
        for (int r = 0; r < 8; r++) begin
            @(negedge clk);
            dbg_reg = reg_addr_t'(r);
            @(negedge clk);
            check_word($sformatf("dbg_data x%0d", r), dbg_data, model_regs[r]);
        end
    endtask

    task automatic check_final_state();
        check_count("store count", stores_seen, store_addr_q.size());
        for (int w = 0; w < MEM_WORDS; w++) begin
            check_word($sformatf("ram[%0d]", w), ram[w], model_ram[w]);
        end
    endtask

    initial begin
        lfsr_state = 32'hcaa13ff8;
        dbg_reg = '0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            ram[w] = fill_word(w);
        end
        gen_program();
        run_model();
        check_reset();
        wait_halt();
        check_registers();
        check_final_state();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- rv5.f
+incdir+src
src/rv5_pkg.sv
src/rv5_fetch.sv
src/rv5_decode.sv
src/rv5_regfile.sv
src/rv5_execute.sv
src/rv5_memwb.sv
src/rv5_hazard.sv
src/rv5_core.sv
bench/rv5_clock_gen.sv
bench/rv5_assert.sv
bench/rv5_tb.sv
